// File: src/bm_pkg.sv
// ####################################################################
// Fixed 64-bit datapath. W forms use the low 32 bits only
// Operation codes 27 to 31 are unsupported and complete with zero
// ####################################################################
package bm_pkg;

	localparam int DATA_W     = 64;
	localparam int HALF_W     = 32;   // W variants and PACK halves
	localparam int OP_W       = 5;
	localparam int TRANS_ID_W = 3;
	localparam int FUNC_W     = 4;
	localparam int UNIT_W     = 3;

	// Bit positions in the one-hot unit select
	localparam int UNIT_BITCNT  = 0;
	localparam int UNIT_SHIFTER = 1;
	localparam int UNIT_SIMPLE  = 2;

	// Operation codes, grouped by unit
	localparam logic [OP_W-1:0] OP_CLZ   = 5'd0;
	localparam logic [OP_W-1:0] OP_CLZW  = 5'd1;
	localparam logic [OP_W-1:0] OP_CTZ   = 5'd2;
	localparam logic [OP_W-1:0] OP_CTZW  = 5'd3;
	localparam logic [OP_W-1:0] OP_PCNT  = 5'd4;
	localparam logic [OP_W-1:0] OP_PCNTW = 5'd5;
	localparam logic [OP_W-1:0] OP_SEXTB = 5'd6;
	localparam logic [OP_W-1:0] OP_SEXTH = 5'd7;
	localparam logic [OP_W-1:0] OP_SLL   = 5'd8;
	localparam logic [OP_W-1:0] OP_SRL   = 5'd9;
	localparam logic [OP_W-1:0] OP_SRA   = 5'd10;
	localparam logic [OP_W-1:0] OP_ROL   = 5'd11;
	localparam logic [OP_W-1:0] OP_ROR   = 5'd12;
	localparam logic [OP_W-1:0] OP_SBSET = 5'd13;
	localparam logic [OP_W-1:0] OP_SBCLR = 5'd14;
	localparam logic [OP_W-1:0] OP_SBINV = 5'd15;
	localparam logic [OP_W-1:0] OP_SBEXT = 5'd16;
	localparam logic [OP_W-1:0] OP_ANDN  = 5'd17;
	localparam logic [OP_W-1:0] OP_ORN   = 5'd18;
	localparam logic [OP_W-1:0] OP_XNOR  = 5'd19;
	localparam logic [OP_W-1:0] OP_MIN   = 5'd20;
	localparam logic [OP_W-1:0] OP_MAX   = 5'd21;
	localparam logic [OP_W-1:0] OP_MINU  = 5'd22;
	localparam logic [OP_W-1:0] OP_MAXU  = 5'd23;
	localparam logic [OP_W-1:0] OP_PACK  = 5'd24;
	localparam logic [OP_W-1:0] OP_PACKU = 5'd25;
	localparam logic [OP_W-1:0] OP_PACKH = 5'd26;

	// Function index inside the bit-count unit
	localparam logic [FUNC_W-1:0] FUNC_CLZ   = 4'd0;
	localparam logic [FUNC_W-1:0] FUNC_CLZW  = 4'd1;
	localparam logic [FUNC_W-1:0] FUNC_CTZ   = 4'd2;
	localparam logic [FUNC_W-1:0] FUNC_CTZW  = 4'd3;
	localparam logic [FUNC_W-1:0] FUNC_PCNT  = 4'd4;
	localparam logic [FUNC_W-1:0] FUNC_PCNTW = 4'd5;
	localparam logic [FUNC_W-1:0] FUNC_SEXTB = 4'd6;
	localparam logic [FUNC_W-1:0] FUNC_SEXTH = 4'd7;

	// Function index inside the shifter
	localparam logic [FUNC_W-1:0] FUNC_SLL   = 4'd0;
	localparam logic [FUNC_W-1:0] FUNC_SRL   = 4'd1;
	localparam logic [FUNC_W-1:0] FUNC_SRA   = 4'd2;
	localparam logic [FUNC_W-1:0] FUNC_ROL   = 4'd3;
	localparam logic [FUNC_W-1:0] FUNC_ROR   = 4'd4;
	localparam logic [FUNC_W-1:0] FUNC_SBSET = 4'd5;
	localparam logic [FUNC_W-1:0] FUNC_SBCLR = 4'd6;
	localparam logic [FUNC_W-1:0] FUNC_SBINV = 4'd7;
	localparam logic [FUNC_W-1:0] FUNC_SBEXT = 4'd8;

	// Function index inside the simple-logic unit
	localparam logic [FUNC_W-1:0] FUNC_ANDN  = 4'd0;
	localparam logic [FUNC_W-1:0] FUNC_ORN   = 4'd1;
	localparam logic [FUNC_W-1:0] FUNC_XNOR  = 4'd2;
	localparam logic [FUNC_W-1:0] FUNC_MIN   = 4'd3;
	localparam logic [FUNC_W-1:0] FUNC_MAX   = 4'd4;
	localparam logic [FUNC_W-1:0] FUNC_MINU  = 4'd5;
	localparam logic [FUNC_W-1:0] FUNC_MAXU  = 4'd6;
	localparam logic [FUNC_W-1:0] FUNC_PACK  = 4'd7;
	localparam logic [FUNC_W-1:0] FUNC_PACKU = 4'd8;
	localparam logic [FUNC_W-1:0] FUNC_PACKH = 4'd9;

endpackage

// File: src/bm_op_decoder.sv
// ####################################################################
// Purely combinational. Unsupported codes give an all-zero select
// ####################################################################
`timescale 1ns/10ps

module bm_op_decoder import bm_pkg::*; (
	input  logic [OP_W-1:0]   op_i,
	output logic [UNIT_W-1:0] unit_sel_o,  // One-hot, zero if unsupported
	output logic [FUNC_W-1:0] func_sel_o
);

	always_comb begin
		case (op_i)
			OP_CLZ:   {unit_sel_o, func_sel_o} = {UNIT_W'(1) << UNIT_BITCNT, FUNC_CLZ};
			OP_CLZW:  {unit_sel_o, func_sel_o} = {UNIT_W'(1) << UNIT_BITCNT, FUNC_CLZW};
			OP_CTZ:   {unit_sel_o, func_sel_o} = {UNIT_W'(1) << UNIT_BITCNT, FUNC_CTZ};
			OP_CTZW:  {unit_sel_o, func_sel_o} = {UNIT_W'(1) << UNIT_BITCNT, FUNC_CTZW};
			OP_PCNT:  {unit_sel_o, func_sel_o} = {UNIT_W'(1) << UNIT_BITCNT, FUNC_PCNT};
			OP_PCNTW: {unit_sel_o, func_sel_o} = {UNIT_W'(1) << UNIT_BITCNT, FUNC_PCNTW};
			OP_SEXTB: {unit_sel_o, func_sel_o} = {UNIT_W'(1) << UNIT_BITCNT, FUNC_SEXTB};
			OP_SEXTH: {unit_sel_o, func_sel_o} = {UNIT_W'(1) << UNIT_BITCNT, FUNC_SEXTH};

			OP_SLL:   {unit_sel_o, func_sel_o} = {UNIT_W'(1) << UNIT_SHIFTER, FUNC_SLL};
			OP_SRL:   {unit_sel_o, func_sel_o} = {UNIT_W'(1) << UNIT_SHIFTER, FUNC_SRL};
			OP_SRA:   {unit_sel_o, func_sel_o} = {UNIT_W'(1) << UNIT_SHIFTER, FUNC_SRA};
			OP_ROL:   {unit_sel_o, func_sel_o} = {UNIT_W'(1) << UNIT_SHIFTER, FUNC_ROL};
			OP_ROR:   {unit_sel_o, func_sel_o} = {UNIT_W'(1) << UNIT_SHIFTER, FUNC_ROR};
			OP_SBSET: {unit_sel_o, func_sel_o} = {UNIT_W'(1) << UNIT_SHIFTER, FUNC_SBSET};
			OP_SBCLR: {unit_sel_o, func_sel_o} = {UNIT_W'(1) << UNIT_SHIFTER, FUNC_SBCLR};
			OP_SBINV: {unit_sel_o, func_sel_o} = {UNIT_W'(1) << UNIT_SHIFTER, FUNC_SBINV};
			OP_SBEXT: {unit_sel_o, func_sel_o} = {UNIT_W'(1) << UNIT_SHIFTER, FUNC_SBEXT};

			OP_ANDN:  {unit_sel_o, func_sel_o} = {UNIT_W'(1) << UNIT_SIMPLE, FUNC_ANDN};
			OP_ORN:   {unit_sel_o, func_sel_o} = {UNIT_W'(1) << UNIT_SIMPLE, FUNC_ORN};
			OP_XNOR:  {unit_sel_o, func_sel_o} = {UNIT_W'(1) << UNIT_SIMPLE, FUNC_XNOR};
			OP_MIN:   {unit_sel_o, func_sel_o} = {UNIT_W'(1) << UNIT_SIMPLE, FUNC_MIN};
			OP_MAX:   {unit_sel_o, func_sel_o} = {UNIT_W'(1) << UNIT_SIMPLE, FUNC_MAX};
			OP_MINU:  {unit_sel_o, func_sel_o} = {UNIT_W'(1) << UNIT_SIMPLE, FUNC_MINU};
			OP_MAXU:  {unit_sel_o, func_sel_o} = {UNIT_W'(1) << UNIT_SIMPLE, FUNC_MAXU};
			OP_PACK:  {unit_sel_o, func_sel_o} = {UNIT_W'(1) << UNIT_SIMPLE, FUNC_PACK};
			OP_PACKU: {unit_sel_o, func_sel_o} = {UNIT_W'(1) << UNIT_SIMPLE, FUNC_PACKU};
			OP_PACKH: {unit_sel_o, func_sel_o} = {UNIT_W'(1) << UNIT_SIMPLE, FUNC_PACKH};

			default: begin
				unit_sel_o = '0;  // No unit claims the code
				func_sel_o = '0;
			end
		endcase
	end

endmodule

// File: src/bm_bitcnt.sv
// ####################################################################
// Combinational. A zero input counts as the full width, 64 or 32
// ####################################################################
`timescale 1ns/10ps

module bm_bitcnt import bm_pkg::*; (
	input  logic [FUNC_W-1:0] func_i,
	input  logic [DATA_W-1:0] rs1_i,
	output logic [DATA_W-1:0] rd_o
);

	logic [DATA_W-1:0] lz_in;
	logic [DATA_W-1:0] pc_in;
	int                lz_cnt;
	int                pc_cnt;

	// Trailing counts run the same leading-zero scan on the reversed word
	always_comb begin
		case (func_i)
			FUNC_CLZW: lz_in = {rs1_i[HALF_W-1:0], {HALF_W{1'b1}}};  // Ones stop scan at 32
			FUNC_CTZ:  lz_in = {<<{rs1_i}};
			FUNC_CTZW: lz_in = {<<{{HALF_W{1'b1}}, rs1_i[HALF_W-1:0]}};
			default:   lz_in = rs1_i;
		endcase
	end

	// Highest set bit wins since the loop runs upward
	always_comb begin
		lz_cnt = DATA_W;
		for (int i = 0; i < DATA_W; i++) begin
			if (lz_in[i])
				lz_cnt = DATA_W - 1 - i;
		end
	end

	assign pc_in  = (func_i == FUNC_PCNTW) ? {{HALF_W{1'b0}}, rs1_i[HALF_W-1:0]} : rs1_i;
	assign pc_cnt = $countones(pc_in);

	always_comb begin
		case (func_i)
			FUNC_CLZ, FUNC_CLZW, FUNC_CTZ, FUNC_CTZW: begin
				rd_o = DATA_W'(lz_cnt);
			end
			FUNC_PCNT, FUNC_PCNTW: begin
				rd_o = DATA_W'(pc_cnt);
			end
			FUNC_SEXTB: rd_o = {{(DATA_W-8){rs1_i[7]}}, rs1_i[7:0]};
			FUNC_SEXTH: rd_o = {{(DATA_W-16){rs1_i[15]}}, rs1_i[15:0]};
			default:    rd_o = '0;  // Unused function index
		endcase
	end

endmodule

// File: src/bm_shifter.sv
// ####################################################################
// Combinational. Only the low 6 bits of rs2 are used as the amount
// Single-bit operations index with the same 6 bits
// ####################################################################
`timescale 1ns/10ps

module bm_shifter import bm_pkg::*; (
	input  logic [FUNC_W-1:0] func_i,
	input  logic [DATA_W-1:0] rs1_i,
	input  logic [DATA_W-1:0] rs2_i,
	output logic [DATA_W-1:0] rd_o
);

	logic [$clog2(DATA_W)-1:0] shamt;
	logic [2*DATA_W-1:0]       rol_w;
	logic [2*DATA_W-1:0]       ror_w;
	logic [DATA_W-1:0]         bit_mask;

	assign shamt = rs2_i[$clog2(DATA_W)-1:0];

	// Rotates shift a doubled word and keep one half
	assign rol_w = {rs1_i, rs1_i} << shamt;
	assign ror_w = {rs1_i, rs1_i} >> shamt;

	assign bit_mask = {{(DATA_W-1){1'b0}}, 1'b1} << shamt;

	always_comb begin
		case (func_i)
			FUNC_SLL:   rd_o = rs1_i << shamt;
			FUNC_SRL:   rd_o = rs1_i >> shamt;
			FUNC_SRA:   rd_o = $signed(rs1_i) >>> shamt;
			FUNC_ROL:   rd_o = rol_w[2*DATA_W-1:DATA_W];  // Upper half
			FUNC_ROR:   rd_o = ror_w[DATA_W-1:0];         // Lower half
			FUNC_SBSET: rd_o = rs1_i | bit_mask;
			FUNC_SBCLR: rd_o = rs1_i & ~bit_mask;
			FUNC_SBINV: rd_o = rs1_i ^ bit_mask;
			FUNC_SBEXT: rd_o = {{(DATA_W-1){1'b0}}, rs1_i[shamt]};
			default:    rd_o = '0;
		endcase
	end

endmodule

// File: src/bm_simple.sv
// ####################################################################
// Combinational. PACKH zero-extends the joined bytes
// ####################################################################
`timescale 1ns/10ps

module bm_simple import bm_pkg::*; (
	input  logic [FUNC_W-1:0] func_i,
	input  logic [DATA_W-1:0] rs1_i,
	input  logic [DATA_W-1:0] rs2_i,
	output logic [DATA_W-1:0] rd_o
);

	logic lt_signed;
	logic lt_unsigned;

	// One comparator each, shared by min and max
	assign lt_signed   = $signed(rs1_i) < $signed(rs2_i);
	assign lt_unsigned = rs1_i < rs2_i;

	always_comb begin
		case (func_i)
			FUNC_ANDN:  rd_o = rs1_i & ~rs2_i;
			FUNC_ORN:   rd_o = rs1_i | ~rs2_i;
			FUNC_XNOR:  rd_o = rs1_i ^ ~rs2_i;
			FUNC_MIN:   rd_o = lt_signed ? rs1_i : rs2_i;
			FUNC_MAX:   rd_o = lt_signed ? rs2_i : rs1_i;
			FUNC_MINU:  rd_o = lt_unsigned ? rs1_i : rs2_i;
			FUNC_MAXU:  rd_o = lt_unsigned ? rs2_i : rs1_i;
			FUNC_PACK: begin
				rd_o = {rs2_i[HALF_W-1:0], rs1_i[HALF_W-1:0]};  // rs1 low half at bottom
			end
			FUNC_PACKU: begin
				rd_o = {rs2_i[DATA_W-1:HALF_W], rs1_i[DATA_W-1:HALF_W]};
			end
			FUNC_PACKH: begin
				rd_o = {{(DATA_W-16){1'b0}}, rs2_i[7:0], rs1_i[7:0]};
			end
			default:    rd_o = '0;
		endcase
	end

endmodule

// File: src/bm_unit.sv
// ####################################################################
// One operation in flight, result two edges after acceptance
// No output back-pressure. Flush drops the operation in flight
// ####################################################################
`timescale 1ns/10ps

module bm_unit import bm_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  flush_i,
	input  logic                  valid_i,     // Raised only while ready_o is high
	output logic                  ready_o,
	input  logic [OP_W-1:0]       op_i,
	input  logic [DATA_W-1:0]     operand_a_i,
	input  logic [DATA_W-1:0]     operand_b_i,
	input  logic [TRANS_ID_W-1:0] trans_id_i,
	output logic                  valid_o,     // One-cycle strobe
	output logic [DATA_W-1:0]     result_o,
	output logic [TRANS_ID_W-1:0] trans_id_o
);

	logic                  clear;
	logic                  accept;
	logic [UNIT_W-1:0]     dec_unit;
	logic [FUNC_W-1:0]     dec_func;
	logic                  busy;
	logic [UNIT_W-1:0]     in_unit;
	logic [FUNC_W-1:0]     in_func;
	logic [DATA_W-1:0]     in_rs1;
	logic [DATA_W-1:0]     in_rs2;
	logic [TRANS_ID_W-1:0] in_id;
	logic [DATA_W-1:0]     bitcnt_rd;
	logic [DATA_W-1:0]     shifter_rd;
	logic [DATA_W-1:0]     simple_rd;
	logic [DATA_W-1:0]     sel_rd;

	assign clear   = reset | flush_i;
	assign accept  = valid_i & ready_o;
	assign ready_o = ~busy;

	bm_op_decoder i_decoder (
		.op_i      (op_i),
		.unit_sel_o(dec_unit),
		.func_sel_o(dec_func)
	);

	// Busy flag and input stage control
	always_ff @(posedge clock) begin
		if (clear) begin
			busy    <= 1'b0;
			in_unit <= '0;
		end else begin
			busy <= accept;  // Every operation takes exactly one cycle here
			if (accept)
				in_unit <= dec_unit;
		end
	end

	// Operand and id capture
	always_ff @(posedge clock) begin
		if (accept) begin
			in_func <= dec_func;
			in_rs1  <= operand_a_i;
			in_rs2  <= operand_b_i;
			in_id   <= trans_id_i;
		end
	end

	bm_bitcnt i_bitcnt (
		.func_i(in_func),
		.rs1_i (in_rs1),
		.rd_o  (bitcnt_rd)
	);

	bm_shifter i_shifter (
		.func_i(in_func),
		.rs1_i (in_rs1),
		.rs2_i (in_rs2),
		.rd_o  (shifter_rd)
	);

	bm_simple i_simple (
		.func_i(in_func),
		.rs1_i (in_rs1),
		.rs2_i (in_rs2),
		.rd_o  (simple_rd)
	);

	always_comb begin
		sel_rd = '0;  // Unsupported code completes with zero
		if (in_unit[UNIT_BITCNT])
			sel_rd = bitcnt_rd;
		if (in_unit[UNIT_SHIFTER])
			sel_rd = shifter_rd;
		if (in_unit[UNIT_SIMPLE])
			sel_rd = simple_rd;
	end

	// Output register, loads on the edge after acceptance
	always_ff @(posedge clock) begin
		if (clear) begin
			valid_o    <= 1'b0;
			result_o   <= '0;
			trans_id_o <= '0;
		end else begin
			valid_o <= busy;
			if (busy) begin
				result_o   <= sel_rd;
				trans_id_o <= in_id;
			end
		end
	end

endmodule

// File: include/bm_model.svh
// ####################################################################
// Behavioral reference for the testbench, bm_pkg must be imported
// Codes outside 0 to 26 return zero, as the unit does
// ####################################################################
`ifndef BM_MODEL_SVH
`define BM_MODEL_SVH

function automatic logic [DATA_W-1:0] bm_model(
	input logic [OP_W-1:0]   op,
	input logic [DATA_W-1:0] a,
	input logic [DATA_W-1:0] b
);
	int                n;
	int                sh;
	logic [DATA_W-1:0] r;

	n  = 0;
	sh = int'(b[5:0]);
	r  = '0;
	case (op)
		OP_CLZ: begin
			while (n < DATA_W && !a[DATA_W-1-n]) n++;
			r = DATA_W'(n);
		end
		OP_CLZW: begin
			while (n < HALF_W && !a[HALF_W-1-n]) n++;
			r = DATA_W'(n);
		end
		OP_CTZ: begin
			while (n < DATA_W && !a[n]) n++;
			r = DATA_W'(n);
		end
		OP_CTZW: begin
			while (n < HALF_W && !a[n]) n++;
			r = DATA_W'(n);
		end
		OP_PCNT:  r = DATA_W'($countones(a));
		OP_PCNTW: r = DATA_W'($countones(a[HALF_W-1:0]));
		OP_SEXTB: r = DATA_W'($signed(a[7:0]));
		OP_SEXTH: r = DATA_W'($signed(a[15:0]));
		OP_SLL:   r = a << sh;
		OP_SRL:   r = a >> sh;
		OP_SRA:   r = $signed(a) >>> sh;
		OP_ROL:   r = (a << sh) | (a >> (DATA_W - sh));  // Zero amount shifts out fully
		OP_ROR:   r = (a >> sh) | (a << (DATA_W - sh));
		OP_SBSET: r = a | (DATA_W'(1) << sh);
		OP_SBCLR: r = a & ~(DATA_W'(1) << sh);
		OP_SBINV: r = a ^ (DATA_W'(1) << sh);
		OP_SBEXT: r = DATA_W'(a[sh]);
		OP_ANDN:  r = a & ~b;
		OP_ORN:   r = a | ~b;
		OP_XNOR:  r = ~(a ^ b);
		OP_MIN:   r = ($signed(a) < $signed(b)) ? a : b;
		OP_MAX:   r = ($signed(a) < $signed(b)) ? b : a;
		OP_MINU:  r = (a < b) ? a : b;
		OP_MAXU:  r = (a < b) ? b : a;
		OP_PACK:  r = {b[HALF_W-1:0], a[HALF_W-1:0]};
		OP_PACKU: r = {b[DATA_W-1:HALF_W], a[DATA_W-1:HALF_W]};
		OP_PACKH: r = {{(DATA_W-16){1'b0}}, b[7:0], a[7:0]};
		default:  r = '0;
	endcase
	return r;
endfunction

`endif

// File: sim/bm_unit_tb.sv
// ####################################################################
// Galois LFSR stimulus with seed 32'h3b1e and one step per bit taken
// Expected values come from bm_model.svh with one operation in flight
// ####################################################################
`timescale 1ns/10ps

module bm_unit_tb import bm_pkg::*; ();

`include "bm_model.svh"

	localparam int CLK_NS      = 8;
	localparam int NUM_OPS     = 300 + 40 + 10 + 10;  // Random, back-to-back, unsupported, flush
	localparam int WATCHDOG_NS = (NUM_OPS * 10 + 200) * CLK_NS;

	logic                  clock;
	logic                  reset;
	logic                  flush_i;
	logic                  valid_i;
	logic                  ready_o;
	logic [OP_W-1:0]       op_i;
	logic [DATA_W-1:0]     operand_a_i;
	logic [DATA_W-1:0]     operand_b_i;
	logic [TRANS_ID_W-1:0] trans_id_i;
	logic                  valid_o;
	logic [DATA_W-1:0]     result_o;
	logic [TRANS_ID_W-1:0] trans_id_o;

	logic [31:0]           lfsr_state;
	int                    edge_cnt = 0;
	int                    errors = 0;
	int                    checks = 0;
	int                    results = 0;
	int                    test_errors = 0;
	int                    exp_due[$];     // edge_cnt value when valid_o is due
	logic [DATA_W-1:0]     exp_result[$];
	logic [TRANS_ID_W-1:0] exp_id[$];

	bm_unit i_dut (
		.clock      (clock),
		.reset      (reset),
		.flush_i    (flush_i),
		.valid_i    (valid_i),
		.ready_o    (ready_o),
		.op_i       (op_i),
		.operand_a_i(operand_a_i),
		.operand_b_i(operand_b_i),
		.trans_id_i (trans_id_i),
		.valid_o    (valid_o),
		.result_o   (result_o),
		.trans_id_o (trans_id_o)
	);

	always #(CLK_NS / 2) clock = ~clock;

	always @(posedge clock) edge_cnt <= edge_cnt + 1;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic draw_bits(input int n, output logic [63:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[62:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic draw_operand(output logic [DATA_W-1:0] v);
		logic [63:0] kind;
		logic [63:0] pos;
		draw_bits(3, kind);
		case (kind[2:0])
			3'd0: v = '0;
			3'd1: v = '1;
			3'd2: begin
				draw_bits(6, pos);
				v = DATA_W'(1) << pos[5:0];  // Single bit set
			end
			default: draw_bits(64, v);
		endcase
	endtask

	task automatic draw_inputs(output logic [OP_W-1:0] op, output logic [DATA_W-1:0] a,
		output logic [DATA_W-1:0] b, output logic [TRANS_ID_W-1:0] id);
		logic [63:0] r;
		draw_bits(5, r);
		op = OP_W'(r % 27);  // Supported codes only
		draw_operand(a);
		draw_operand(b);
		draw_bits(TRANS_ID_W, r);
		id = r[TRANS_ID_W-1:0];
	endtask

	task automatic check_value(input string what, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			$display("FAIL at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
			errors++;
		end
	endtask

	// Starts and returns on a falling edge, in the cycle after acceptance
	task automatic issue_op(input logic [OP_W-1:0] op, input logic [DATA_W-1:0] a,
		input logic [DATA_W-1:0] b, input logic [TRANS_ID_W-1:0] id);
		while (!ready_o)
			@(negedge clock);
		valid_i     = 1'b1;
		op_i        = op;
		operand_a_i = a;
		operand_b_i = b;
		trans_id_i  = id;
		exp_due.push_back(edge_cnt + 2);
		exp_result.push_back(bm_model(op, a, b));
		exp_id.push_back(id);
		@(negedge clock);
		valid_i = 1'b0;
	endtask

	task automatic pop_expected();
		void'(exp_due.pop_front());
		void'(exp_result.pop_front());
		void'(exp_id.pop_front());
	endtask

	task automatic wait_idle();
		while (exp_due.size() != 0)
			@(negedge clock);
		@(negedge clock);
	endtask

	task automatic finish_test(input string name);
		$display("%s finished, %0d errors", name, errors - test_errors);
		test_errors = errors;
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clock) begin
		if (!reset) begin
			if (exp_due.size() != 0 && edge_cnt == exp_due[0] - 1)
				check_value("ready_o while busy", 64'(ready_o), 64'd0);
			if (valid_o && exp_due.size() == 0) begin
				$display("Error at %0t ns: result strobe with no operation in flight", $time);
				errors++;
			end else if (valid_o) begin
				check_value("result latency", 64'(edge_cnt), 64'(exp_due[0]));
				check_value("ready_o with result", 64'(ready_o), 64'd1);
				check_value("result_o", result_o, exp_result[0]);
				check_value("trans_id_o", 64'(trans_id_o), 64'(exp_id[0]));
				pop_expected();
				results++;
			end else if (exp_due.size() != 0 && edge_cnt >= exp_due[0]) begin
				$display("Error at %0t ns: no result strobe for id %0d", $time, exp_id[0]);
				errors++;
				pop_expected();
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired at %0t ns before all tests ended", $time);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		logic [OP_W-1:0]       op;
		logic [DATA_W-1:0]     a;
		logic [DATA_W-1:0]     b;
		logic [TRANS_ID_W-1:0] id;
		logic [63:0]           gap;
		int                    base;

		clock       = 1'b0;
		reset       = 1'b1;
		flush_i     = 1'b0;
		valid_i     = 1'b0;
		op_i        = '0;
		operand_a_i = '0;
		operand_b_i = '0;
		trans_id_i  = '0;
		lfsr_state  = 32'h3b1e;
		repeat (4) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		check_value("ready_o after reset", 64'(ready_o), 64'd1);
		check_value("result_o after reset", result_o, 64'd0);
		check_value("trans_id_o after reset", 64'(trans_id_o), 64'd0);
		repeat (5) begin
			check_value("valid_o before first operation", 64'(valid_o), 64'd0);
			@(negedge clock);
		end
		finish_test("Test 1 reset state");

		for (int i = 0; i < 300; i++) begin
			draw_inputs(op, a, b, id);
			draw_bits(2, gap);
			repeat (int'(gap[1:0])) @(negedge clock);  // Idle gap of 0 to 3 cycles
			issue_op(op, a, b, id);
		end
		wait_idle();
		finish_test("Test 2 random operations");

		base = results;
		for (int i = 0; i < 40; i++) begin
			draw_inputs(op, a, b, id);
			issue_op(op, a, b, id);
		end
		wait_idle();
		check_value("back-to-back result count", 64'(results - base), 64'd40);
		finish_test("Test 3 latency and back-to-back issue");

		for (int i = 0; i < 10; i++) begin
			draw_inputs(op, a, b, id);
			issue_op(OP_W'(27 + i % 5), a, b, TRANS_ID_W'(i));
		end
		wait_idle();
		finish_test("Test 4 ids and unsupported codes");

		for (int i = 0; i < 5; i++) begin
			draw_inputs(op, a, b, id);
			issue_op(op, a, b, id);
			flush_i = 1'b1;  // Cycle after acceptance
			exp_due.delete();
			exp_result.delete();
			exp_id.delete();
			@(negedge clock);
			flush_i = 1'b0;
			check_value("ready_o after flush", 64'(ready_o), 64'd1);
			check_value("valid_o after flush", 64'(valid_o), 64'd0);
			draw_inputs(op, a, b, id);
			issue_op(op, a, b, id);
			wait_idle();
		end
		finish_test("Test 5 flush");

		$display("Checks %0d, results %0d, errors %0d", checks, results, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: files.f
+incdir+include
src/bm_pkg.sv
src/bm_op_decoder.sv
src/bm_bitcnt.sv
src/bm_shifter.sv
src/bm_simple.sv
src/bm_unit.sv
sim/bm_unit_tb.sv

// File: run.sh
#!/bin/sh
# Builds and runs the bm_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f files.f --top-module bm_unit_tb \
	-Mdir obj_dir -o bm_unit_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/bm_unit_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation failed" sim.log; then
	exit 1
fi
exit 0
